// File: all.f
design/eq_pkg.sv
design/lr_sample_capture.sv
design/biquad_mac.sv
design/three_band_eq.sv
sim/tb_eq_checks.sv
sim/tb_three_band_eq.sv

// File: sim/tb_three_band_eq.sv
`timescale 1ns/100ps
`default_nettype none
/* Equalizer testbench, the checks sit in tb_eq_checks. The mid gain is raised
   to about 2.0 so that the output can clip */
module tb_three_band_eq;
    import eq_pkg::*;

    localparam coef_t MID_GAIN     = 16'sh7FFF;    // ~2.0 in Q2.14
    localparam int    CLK_NS       = 10;
    localparam int    RESET_CYCLES = 16;
    localparam int    LR_PERIOD    = 32;           // clk cycles per l_r_clk edge
    localparam int    LAT_SAMPLES  = 4;
    localparam int    EDGE_SAMPLES = 40;
    localparam int    IMP_SAMPLES  = 32;           // Impulse plus zero tail
    localparam int    RAND_SAMPLES = 200;
    localparam int    CLIP_SAMPLES = 40;           // Per polarity
    localparam int    NUM_SAMPLES  = LAT_SAMPLES + EDGE_SAMPLES + IMP_SAMPLES
                                   + RAND_SAMPLES + 2 * CLIP_SAMPLES;
    localparam int    WATCHDOG_NS  = (NUM_SAMPLES + 10) * LR_PERIOD * CLK_NS;

    logic    clk = 1'b0;
    logic    reset;
    logic    l_r_clk;
    sample_t audio_in;
    sample_t audio_out;
    logic    sample_valid;
    int      checker_errors;
    int      toggles;
    int      pulses;
    logic    hit_max;
    logic    hit_min;
    int      tb_errors = 0;
    int      tests_run = 0;
    int      errors_before = 0;
    int      seed = 32'h2c8b4d21;
    int      toggles_start;
    int      pulses_start;

    always #(CLK_NS / 2) clk = ~clk;

    three_band_eq #(
        .MID_B0 (MID_GAIN)
    ) i_dut (
        .clk          (clk),
        .reset        (reset),
        .l_r_clk      (l_r_clk),
        .audio_in     (audio_in),
        .audio_out    (audio_out),
        .sample_valid (sample_valid)
    );

    tb_eq_checks #(
        .MID_B0 (MID_GAIN)
    ) i_checks (
        .clk          (clk),
        .reset        (reset),
        .l_r_clk      (l_r_clk),
        .audio_in     (audio_in),
        .audio_out    (audio_out),
        .sample_valid (sample_valid),
        .errors       (checker_errors),
        .toggles      (toggles),
        .pulses       (pulses),
        .hit_max      (hit_max),
        .hit_min      (hit_min)
    );

    function automatic int total_errors();
        return checker_errors + tb_errors;
    endfunction

    // One l_r_clk edge with a new sample, wait for the result, pad out the period
    task automatic send_sample(input sample_t value);
        int cycles;
        @(posedge clk);
        audio_in <= value;
        l_r_clk  <= ~l_r_clk;
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
        end while (!sample_valid && cycles < LR_PERIOD - 1);
        if (!sample_valid) begin
            $display("No sample_valid within %0d cycles of the edge before %0t", cycles, $time);
            tb_errors++;
        end
        repeat (LR_PERIOD - 1 - cycles) @(posedge clk);
    endtask

    task automatic play_random(input int count);
        repeat (count) send_sample(sample_t'($random(seed)));
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        $display("Test %0d (%s) finished with %0d failures", tests_run, name,
                 total_errors() - errors_before);
        errors_before = total_errors();
    endtask

    initial begin
        reset    = 1'b0;
        l_r_clk  = 1'b0;    // Low through reset, as the capture expects
        audio_in = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b1;

        repeat (2 * LR_PERIOD) @(posedge clk);     // No edge yet, outputs stay 0
        finish_test("reset state");

        play_random(LAT_SAMPLES);
        finish_test("exact latency");

        toggles_start = toggles;
        pulses_start  = pulses;
        play_random(EDGE_SAMPLES);
        assert (pulses - pulses_start == EDGE_SAMPLES && toggles - toggles_start == EDGE_SAMPLES)
        else begin
            $display("Error at %0t: %0d sample_valid pulses for %0d l_r_clk edges", $time,
                     pulses - pulses_start, toggles - toggles_start);
            tb_errors++;
        end
        finish_test("both edges count");

        send_sample(16'sd16384);                   // Impulse, then let it ring out
        repeat (IMP_SAMPLES - 1) send_sample('0);
        play_random(RAND_SAMPLES);
        finish_test("bit-exact filtering");

        repeat (CLIP_SAMPLES) send_sample(16'sh7FFF);
        repeat (CLIP_SAMPLES) send_sample(16'sh8000);
        assert (hit_max && hit_min) else begin
            $display("Output never reached both full scale limits during the clip run");
            tb_errors++;
        end
        finish_test("saturation");

        $display("Tests run %0d, checker failures %0d, testbench failures %0d",
                 tests_run, checker_errors, tb_errors);
        if (total_errors() == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    // Stops a stuck run, bound set by the total sample count
    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns before the tests completed", WATCHDOG_NS);
        $display("Errors found");
        $finish;
    end

endmodule

`default_nettype wire

// File: sim/tb_eq_checks.sv
`timescale 1ns/100ps
`default_nettype none
/* Bit-exact cascade model and output checks. Low and high coefficients match the
   top level defaults, and only the mid gain comes in as a parameter */
module tb_eq_checks #(
    parameter eq_pkg::coef_t MID_B0 = 16'sh4000     // Mid gain as set on the DUT
) (
    input  logic            clk,
    input  logic            reset,
    input  logic            l_r_clk,
    input  eq_pkg::sample_t audio_in,
    input  eq_pkg::sample_t audio_out,
    input  logic            sample_valid,
    output int              errors,         // Failed checks so far
    output int              toggles,        // l_r_clk edges seen
    output int              pulses,         // sample_valid pulses seen
    output logic            hit_max,        // Output reached +full scale
    output logic            hit_min         // Output reached -full scale
);
    import eq_pkg::*;

    localparam int Y_MAX = (1 <<< (SAMPLE_W - 1)) - 1;
    localparam int Y_MIN = -(1 <<< (SAMPLE_W - 1));
    localparam logic signed [ACC_W-1:0] HALF_LSB = 1 <<< (COEF_FRAC - 1);

    // Index 0 is the low shelf, 1 the mid band and 2 the high shelf
    // A terms are stored negated
    localparam coef_t B0_TAB [3] = '{16'sh03EE, MID_B0, 16'sh4000};
    localparam coef_t B1_TAB [3] = '{16'sh03EE, 16'sh0000, 16'sh0000};
    localparam coef_t B2_TAB [3] = '{16'sh0000, 16'sh0000, 16'sh0000};
    localparam coef_t A1_TAB [3] = '{16'sh3823, 16'sh0000, 16'sh0000};
    localparam coef_t A2_TAB [3] = '{16'sh0000, 16'sh0000, 16'sh0000};

    sample_t x1 [3];                // Per stage history
    sample_t x2 [3];
    sample_t y1 [3];
    sample_t y2 [3];
    sample_t model_y;               // Expected output for the latest edge
    logic    lr_last;
    logic    seen_toggle = 1'b0;
    logic    started = 1'b0;        // Past the first clock edge
    int      error_count = 0;

    assign errors = error_count;

    // One stage sums five products in 40 bits, rounds at bit 13 and clips to 16 bits
    function automatic sample_t biquad_ref(input int s, input sample_t x);
        logic signed [ACC_W-1:0] sum;
        logic signed [ACC_W-1:0] scaled;
        sum = B0_TAB[s] * x + B1_TAB[s] * x1[s] + B2_TAB[s] * x2[s]
            + A1_TAB[s] * y1[s] + A2_TAB[s] * y2[s];
        scaled = (sum + HALF_LSB) >>> COEF_FRAC;
        if (scaled > Y_MAX) begin
            return sample_t'(Y_MAX);
        end else if (scaled < Y_MIN) begin
            return sample_t'(Y_MIN);
        end
        return sample_t'(scaled);
    endfunction

    always @(posedge clk) begin : model_update
        sample_t v;
        sample_t y;
        started <= 1'b1;
        lr_last <= l_r_clk;
        if (!reset) begin
            for (int s = 0; s < 3; s++) begin
                x1[s] = '0;
                x2[s] = '0;
                y1[s] = '0;
                y2[s] = '0;
            end
            model_y     <= '0;
            seen_toggle <= 1'b0;
            toggles     <= 0;
            pulses      <= 0;
            hit_max     <= 1'b0;
            hit_min     <= 1'b0;
        end else begin
            if (sample_valid) begin
                pulses <= pulses + 1;
                if (audio_out == sample_t'(Y_MAX)) hit_max <= 1'b1;  // Clipped high
                if (audio_out == sample_t'(Y_MIN)) hit_min <= 1'b1;  // Clipped low
            end
            if (l_r_clk != lr_last) begin
                v = audio_in;                       // Input held across the edge
                for (int s = 0; s < 3; s++) begin
                    y = biquad_ref(s, v);
                    x2[s] = x1[s];                  // History moves once per sample
                    x1[s] = v;
                    y2[s] = y1[s];
                    y1[s] = y;
                    v = y;                          // Feeds the next stage
                end
                model_y     <= v;
                seen_toggle <= 1'b1;
                toggles     <= toggles + 1;
            end
        end
    end

    // Outputs stay quiet until the first sample
    a_reset_quiet : assert property (
        @(posedge clk) (started && !seen_toggle) |-> (!sample_valid && audio_out == '0)
    ) else begin
        error_count = error_count + 1;
        $display("Error at %0t: output active before the first sample, audio_out %0d",
                 $time, $sampled(audio_out));
    end

    a_latency : assert property (
        @(posedge clk) disable iff (!reset)
        $changed(l_r_clk) |-> ##21 sample_valid
    ) else begin
        error_count = error_count + 1;
        $display("Error at %0t: sample_valid missing 21 cycles after an l_r_clk edge",
                 $time);
    end

    // Each pulse must trace back to an edge exactly 21 cycles earlier
    a_pulse_source : assert property (
        @(posedge clk) disable iff (!reset)
        sample_valid |-> ($past(l_r_clk, 21) != $past(l_r_clk, 22))
    ) else begin
        error_count = error_count + 1;
        $display("Error at %0t: sample_valid pulsed with no l_r_clk edge 21 cycles before",
                 $time);
    end

    a_output_value : assert property (
        @(posedge clk) disable iff (!reset)
        sample_valid |-> (audio_out == model_y)
    ) else begin
        error_count = error_count + 1;
        $display("Error at %0t: audio_out %0d, expected %0d",
                 $time, $sampled(audio_out), $sampled(model_y));
    end

endmodule

`default_nettype wire

// File: design/three_band_eq.sv
`timescale 1ns/100ps
`default_nettype none
/* Low, mid and high biquads in series on one shared chain for both channels.
   audio_out updates with sample_valid 21 clk cycles after an l_r_clk edge */
module three_band_eq #(
    // Low shelf, A terms negated
    parameter eq_pkg::coef_t LOW_B0  = 16'sh03EE,         // ~0.061
    parameter eq_pkg::coef_t LOW_B1  = 16'sh03EE,         // ~0.061
    parameter eq_pkg::coef_t LOW_B2  = 16'sh0000,
    parameter eq_pkg::coef_t LOW_A1  = 16'sh3823,         // ~0.877
    parameter eq_pkg::coef_t LOW_A2  = 16'sh0000,
    // Mid peaking, unity by default
    parameter eq_pkg::coef_t MID_B0  = eq_pkg::COEF_ONE,
    parameter eq_pkg::coef_t MID_B1  = 16'sh0000,
    parameter eq_pkg::coef_t MID_B2  = 16'sh0000,
    parameter eq_pkg::coef_t MID_A1  = 16'sh0000,
    parameter eq_pkg::coef_t MID_A2  = 16'sh0000,
    // High shelf, unity by default
    parameter eq_pkg::coef_t HIGH_B0 = eq_pkg::COEF_ONE,
    parameter eq_pkg::coef_t HIGH_B1 = 16'sh0000,
    parameter eq_pkg::coef_t HIGH_B2 = 16'sh0000,
    parameter eq_pkg::coef_t HIGH_A1 = 16'sh0000,
    parameter eq_pkg::coef_t HIGH_A2 = 16'sh0000
) (
    input  logic            clk,            // Fast system clock
    input  logic            reset,          // Active low, synchronous
    input  logic            l_r_clk,        // New sample on each edge
    input  eq_pkg::sample_t audio_in,
    output eq_pkg::sample_t audio_out,      // Equalized sample
    output logic            sample_valid    // One cycle with each new audio_out
);
    import eq_pkg::*;

    sample_t sample;            // Captured input
    logic    sample_strobe;
    sample_t low_out;
    logic    low_valid;
    sample_t mid_out;
    logic    mid_valid;
    sample_t high_out;
    logic    high_valid;

    lr_sample_capture u_capture (
        .clk           (clk),
        .reset         (reset),
        .l_r_clk       (l_r_clk),
        .audio_in      (audio_in),
        .sample        (sample),
        .sample_strobe (sample_strobe)
    );

    // Bass band, starts on each captured sample
    biquad_mac #(
        .B0 (LOW_B0),
        .B1 (LOW_B1),
        .B2 (LOW_B2),
        .A1 (LOW_A1),
        .A2 (LOW_A2)
    ) u_low (
        .clk     (clk),
        .reset   (reset),
        .trigger (sample_strobe),
        .x_in    (sample),
        .y_out   (low_out),
        .y_valid (low_valid)
    );

    // Mid band, fed by the low stage result
    biquad_mac #(
        .B0 (MID_B0),
        .B1 (MID_B1),
        .B2 (MID_B2),
        .A1 (MID_A1),
        .A2 (MID_A2)
    ) u_mid (
        .clk     (clk),
        .reset   (reset),
        .trigger (low_valid),
        .x_in    (low_out),
        .y_out   (mid_out),
        .y_valid (mid_valid)
    );

    // Treble band, last in the chain
    biquad_mac #(
        .B0 (HIGH_B0),
        .B1 (HIGH_B1),
        .B2 (HIGH_B2),
        .A1 (HIGH_A1),
        .A2 (HIGH_A2)
    ) u_high (
        .clk     (clk),
        .reset   (reset),
        .trigger (mid_valid),
        .x_in    (mid_out),
        .y_out   (high_out),
        .y_valid (high_valid)
    );

    // Output register, valid delayed to line up with the new value
    always_ff @(posedge clk) begin
        if (!reset) begin
            audio_out    <= '0;
            sample_valid <= 1'b0;
        end else begin
            sample_valid <= high_valid;
            if (high_valid) begin
                audio_out <= high_out;
            end
        end
    end

endmodule

`default_nettype wire

// File: design/biquad_mac.sv
`timescale 1ns/100ps
`default_nettype none
/* Direct Form I biquad with one shared multiplier, y_valid six cycles after trigger.
   A1 and A2 are given negated; a trigger outside ST_IDLE is dropped */
module biquad_mac #(
    parameter eq_pkg::coef_t B0 = eq_pkg::COEF_ONE,    // x[n]
    parameter eq_pkg::coef_t B1 = 16'sh0000,           // x[n-1]
    parameter eq_pkg::coef_t B2 = 16'sh0000,           // x[n-2]
    parameter eq_pkg::coef_t A1 = 16'sh0000,           // y[n-1], already negated
    parameter eq_pkg::coef_t A2 = 16'sh0000            // y[n-2], already negated
) (
    input  logic            clk,
    input  logic            reset,
    input  logic            trigger,    // One-cycle start pulse
    input  eq_pkg::sample_t x_in,       // New x[n], read with trigger
    output eq_pkg::sample_t y_out,      // Held until the next y_valid
    output logic            y_valid     // One cycle per result
);
    import eq_pkg::*;

    localparam logic [2:0] TAP_LAST = 3'd4;    // Five taps, 0..4

    mac_state_e state;
    logic [2:0] tap;                // Current coefficient/operand pair

    // Filter state
    sample_t x_cur;                 // x[n] for this run
    sample_t x_d1;                  // x[n-1]
    sample_t x_d2;                  // x[n-2]
    sample_t y_d1;                  // y[n-1]
    sample_t y_d2;                  // y[n-2]

    // Shared MAC path
    coef_t                   mul_coef;
    sample_t                 mul_op;
    logic signed [PROD_W-1:0] product;
    logic signed [ACC_W-1:0]  product_ext;
    logic signed [ACC_W-1:0]  acc;
    logic signed [ACC_W-1:0]  acc_next;
    sample_t                 y_sat;     // Rounded and clipped final sum

    // Round half up at bit 13, shift out the Q2.14 fraction, clip to 16 bits
    function automatic sample_t round_sat(input logic signed [ACC_W-1:0] sum);
        logic signed [ACC_W-1:0] rounded;
        rounded = (sum + ROUND_HALF) >>> COEF_FRAC;
        if (rounded > SAMPLE_MAX) begin
            return sample_t'(SAMPLE_MAX);
        end else if (rounded < SAMPLE_MIN) begin
            return sample_t'(SAMPLE_MIN);
        end
        return sample_t'(rounded);
    endfunction

    // Tap select, feed-forward taps first
    always_comb begin
        case (tap)
            3'd0: begin
                mul_coef = B0;
                mul_op   = x_cur;
            end
            3'd1: begin
                mul_coef = B1;
                mul_op   = x_d1;
            end
            3'd2: begin
                mul_coef = B2;
                mul_op   = x_d2;
            end
            3'd3: begin
                mul_coef = A1;
                mul_op   = y_d1;
            end
            default: begin
                mul_coef = A2;
                mul_op   = y_d2;
            end
        endcase
    end

    assign product     = mul_coef * mul_op;     // 16x16 signed
    assign product_ext = {{(ACC_W - PROD_W){product[PROD_W-1]}}, product};
    assign acc_next    = acc + product_ext;
    assign y_sat       = round_sat(acc_next);  // Only taken at the last tap

    // Sequencer, delay lines and output register
    always_ff @(posedge clk) begin
        if (!reset) begin
            state   <= ST_IDLE;
            tap     <= '0;
            y_valid <= 1'b0;
            y_out   <= '0;
            x_d1    <= '0;
            x_d2    <= '0;
            y_d1    <= '0;
            y_d2    <= '0;
        end else begin
            y_valid <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (trigger) begin
                        state <= ST_MAC;    // Load cycle
                        tap   <= '0;
                    end
                end
                ST_MAC: begin
                    if (tap == TAP_LAST) begin
                        // Last product goes straight through rounding
                        y_out   <= y_sat;
                        y_valid <= 1'b1;
                        state   <= ST_OUT;
                    end else begin
                        tap <= tap + 3'd1;
                    end
                end
                ST_OUT: begin
                    // History moves only once per result
                    x_d2  <= x_d1;
                    x_d1  <= x_cur;
                    y_d2  <= y_d1;
                    y_d1  <= y_out;
                    state <= ST_IDLE;
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // Accumulator and input latch
    always_ff @(posedge clk) begin
        if (state == ST_IDLE && trigger) begin
            x_cur <= x_in;
            acc   <= '0;
        end else if (state == ST_MAC) begin
            acc <= acc_next;
        end
    end

    a_valid_one_cycle : assert property (
        @(posedge clk) disable iff (!reset)
        y_valid |=> !y_valid
    ) else $error("%0t: y_valid held longer than one cycle", $time);

    a_tap_range : assert property (
        @(posedge clk) disable iff (!reset)
        (state == ST_MAC) |-> (tap <= TAP_LAST)
    ) else $error("%0t: tap counter past last tap", $time);

    // Upstream must not retrigger a busy stage
    a_trigger_idle : assert property (
        @(posedge clk) disable iff (!reset)
        trigger |-> (state == ST_IDLE)
    ) else $error("%0t: trigger while biquad busy", $time);

endmodule

`default_nettype wire

// File: design/lr_sample_capture.sv
`timescale 1ns/100ps
`default_nettype none
/* Either edge of l_r_clk captures one sample. l_r_clk must sit low through reset,
   and its edges must be at least 24 clk cycles apart */
module lr_sample_capture (
    input  logic            clk,
    input  logic            reset,
    input  logic            l_r_clk,        // Asynchronous channel select
    input  eq_pkg::sample_t audio_in,       // Sampled on the detected edge
    output eq_pkg::sample_t sample,         // Held until the next strobe
    output logic            sample_strobe   // One cycle per l_r_clk edge
);

    // Minimum spacing between strobes, in clk cycles
    localparam int MIN_GAP = 24;

    logic lr_meta;      // First synchronizer stage
    logic lr_sync;      // Second synchronizer stage
    logic lr_edge;      // Level change between the two stages

    // Rising and falling edges both count
    assign lr_edge = lr_meta ^ lr_sync;

    always_ff @(posedge clk) begin
        if (!reset) begin
            lr_meta       <= 1'b0;
            lr_sync       <= 1'b0;
            sample_strobe <= 1'b0;
        end else begin
            lr_meta       <= l_r_clk;
            lr_sync       <= lr_meta;
            sample_strobe <= lr_edge;   // Registered edge pulse
        end
    end

    // Sample register loads on the same edge that raises the strobe
    always_ff @(posedge clk) begin
        if (lr_edge) begin
            sample <= audio_in;
        end
    end

    // Input rate limit, the cascade needs this much time per sample
    a_strobe_spacing : assert property (
        @(posedge clk) disable iff (!reset)
        sample_strobe |=> (!sample_strobe) [*MIN_GAP-1]
    ) else $error("%0t: l_r_clk edges closer than %0d cycles", $time, MIN_GAP);

endmodule

`default_nettype wire

// File: design/eq_pkg.sv
`default_nettype none
/* Shared widths and types for the equalizer. Coefficients are Q2.14, and the
   accumulator holds five full-scale products with headroom to spare */
package eq_pkg;

    // Data path widths
    localparam int SAMPLE_W  = 16;                  // Audio sample, two's complement
    localparam int COEF_W    = 16;                  // Filter coefficient
    localparam int COEF_FRAC = 14;                  // Q2.14 fractional bits
    localparam int PROD_W    = SAMPLE_W + COEF_W;   // Full multiplier product
    localparam int ACC_W     = 40;                  // Sum of five products

    // Q-format constants
    localparam logic signed [COEF_W-1:0] COEF_ONE = 16'sh4000;  // 1.0 in Q2.14
    localparam int ROUND_HALF = 1 << (COEF_FRAC - 1);           // Half LSB after shift

    // Output clip limits
    localparam int SAMPLE_MAX = (1 << (SAMPLE_W - 1)) - 1;     // +32767
    localparam int SAMPLE_MIN = -(1 << (SAMPLE_W - 1));        // -32768

    // Audio sample as carried between stages
    typedef logic signed [SAMPLE_W-1:0] sample_t;

    // Q2.14 coefficient, range about -2.0 .. +2.0
    typedef logic signed [COEF_W-1:0] coef_t;

    // Biquad sequencer
    typedef enum logic [1:0] {
        ST_IDLE = 2'd0,     // Waiting for trigger
        ST_MAC  = 2'd1,     // Five multiply-accumulate steps
        ST_OUT  = 2'd2      // Result valid, delay lines shift
    } mac_state_e;

endpackage

`default_nettype wire
